//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_w = 32;                           // data and address width
    localparam logic [word_w-1:0] reset_pc = 32'h0000_0000;   // first fetch address

    typedef enum logic [1:0] {
        st_fetch,                                         // wait for instruction word
        st_exec,                                          // alu, branch, next pc
        st_mem,                                           // lw/sw data access
        st_wb                                             // register write-back
    } cpu_state_t;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        cls_alu, cls_load, cls_store, cls_branch, cls_invalid
    } instr_class_t;

endpackage

`default_nettype wire

//--- source/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic                        req;      // held until done
    logic                        wr;       // 1 = store
    logic [cpu_pkg::word_w-1:0]  addr;
    logic [cpu_pkg::word_w-1:0]  wdata;
    logic [3:0]                  wstrb;
    logic                        done;     // one cycle pulse
    logic [cpu_pkg::word_w-1:0]  rdata;    // valid with done on reads

    modport core   (output req, wr, addr, wdata, wstrb, input  done, rdata);
    modport master (input  req, wr, addr, wdata, wstrb, output done, rdata);

endinterface

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                          aclk,
    input  wire                          arst_n,
    input  wire  [4:0]                   raddr_a,
    input  wire  [4:0]                   raddr_b,
    input  wire                          we,
    input  wire  [4:0]                   waddr,
    input  wire  [cpu_pkg::word_w-1:0]   wdata,
    output logic [cpu_pkg::word_w-1:0]   rdata_a,
    output logic [cpu_pkg::word_w-1:0]   rdata_b
);

    logic [cpu_pkg::word_w-1:0] regs [32];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];   // async read
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire  [cpu_pkg::word_w-1:0]  a,
    input  wire  [cpu_pkg::word_w-1:0]  b,
    input  wire  cpu_pkg::alu_op_t      op,
    output logic [cpu_pkg::word_w-1:0]  y
);

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpu_pkg::alu_add: y = a + b;
            cpu_pkg::alu_sub: y = a - b;
            cpu_pkg::alu_and: y = a & b;
            cpu_pkg::alu_or:  y = a | b;
            cpu_pkg::alu_xor: y = a ^ b;
            cpu_pkg::alu_slt: y = {{(cpu_pkg::word_w-1){1'b0}}, lt_signed};
            cpu_pkg::alu_lui: y = {b[15:0], 16'h0000};   // b << 16
            default:          y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire  [cpu_pkg::word_w-1:0]  instr,
    output logic [4:0]                  rs,
    output logic [4:0]                  rt,
    output logic [4:0]                  wnum,
    output logic [cpu_pkg::word_w-1:0]  imm,
    output cpu_pkg::alu_op_t            alu_op,
    output logic                        use_imm,
    output cpu_pkg::instr_class_t       cls
);

    cpu_pkg::opcode_t opc;
    cpu_pkg::funct_t  fn;

    assign opc = cpu_pkg::opcode_t'(instr[31:26]);
    assign fn  = cpu_pkg::funct_t'(instr[5:0]);
    assign rs  = instr[25:21];
    assign rt  = instr[20:16];

    always_comb begin
        wnum    = instr[20:16];                       // rt for i-type
        imm     = {{16{instr[15]}}, instr[15:0]};     // sign-extended by default
        alu_op  = cpu_pkg::alu_add;
        use_imm = 1'b1;
        cls     = cpu_pkg::cls_invalid;
        case (opc)
            cpu_pkg::op_special: begin
                wnum    = instr[15:11];                // rd
                use_imm = 1'b0;
                cls     = cpu_pkg::cls_alu;
                case (fn)
                    cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                    default:          cls    = cpu_pkg::cls_invalid;
                endcase
            end
            cpu_pkg::op_beq: begin
                use_imm = 1'b0;                        // compares rs with rt
                alu_op  = cpu_pkg::alu_sub;
                cls     = cpu_pkg::cls_branch;
            end
            cpu_pkg::op_addiu: cls = cpu_pkg::cls_alu;
            cpu_pkg::op_lui: begin
                imm    = {16'h0000, instr[15:0]};      // zero-extended
                alu_op = cpu_pkg::alu_lui;
                cls    = cpu_pkg::cls_alu;
            end
            cpu_pkg::op_lw: cls = cpu_pkg::cls_load;
            cpu_pkg::op_sw: cls = cpu_pkg::cls_store;
            default:        cls = cpu_pkg::cls_invalid;   // executed as no-op
        endcase
    end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire                          aclk,
    input  wire                          arst_n,
    mem_bus_if.core                      mem_bus,
    output logic [cpu_pkg::word_w-1:0]   debug_wb_pc,
    output logic [cpu_pkg::word_w-1:0]   debug_wb_rf_wdata,
    output logic [3:0]                   debug_wb_rf_wen,
    output logic [4:0]                   debug_wb_rf_wnum
);

    cpu_pkg::cpu_state_t         state;
    logic [cpu_pkg::word_w-1:0]  pc;
    logic [cpu_pkg::word_w-1:0]  ir;
    logic [cpu_pkg::word_w-1:0]  instr_pc;      // pc of the instruction in flight
    logic [cpu_pkg::word_w-1:0]  result;        // alu result or loaded word
    logic                        req_q;
    logic [4:0]                  rs;
    logic [4:0]                  rt;
    logic [4:0]                  wnum;
    logic [cpu_pkg::word_w-1:0]  imm;
    cpu_pkg::alu_op_t            alu_op;
    logic                        use_imm;
    cpu_pkg::instr_class_t       cls;
    logic [cpu_pkg::word_w-1:0]  rf_a;
    logic [cpu_pkg::word_w-1:0]  rf_b;
    logic [cpu_pkg::word_w-1:0]  alu_y;
    logic                        rf_we;
    logic                        taken;
    logic                        is_mem;

    decoder u_decoder (.instr(ir), .rs(rs), .rt(rt), .wnum(wnum), .imm(imm),
                       .alu_op(alu_op), .use_imm(use_imm), .cls(cls));

    alu u_alu (.a(rf_a), .b(use_imm ? imm : rf_b), .op(alu_op), .y(alu_y));

    reg_file u_reg_file (.aclk(aclk), .arst_n(arst_n), .raddr_a(rs), .raddr_b(rt),
                         .we(rf_we), .waddr(wnum), .wdata(result),
                         .rdata_a(rf_a), .rdata_b(rf_b));

    assign taken  = (cls == cpu_pkg::cls_branch) && (rf_a == rf_b);
    assign is_mem = (cls == cpu_pkg::cls_load) || (cls == cpu_pkg::cls_store);
    assign rf_we  = (state == cpu_pkg::st_wb) &&
                    ((cls == cpu_pkg::cls_alu) || (cls == cpu_pkg::cls_load));

    assign mem_bus.req   = req_q;
    assign mem_bus.wr    = (state == cpu_pkg::st_mem) && (cls == cpu_pkg::cls_store);
    assign mem_bus.addr  = (state == cpu_pkg::st_mem) ? result : pc;   // data or fetch address
    assign mem_bus.wdata = rf_b;                   // rt, stable until write-back
    assign mem_bus.wstrb = mem_bus.wr ? 4'b1111 : 4'b0000;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cpu_pkg::st_fetch;
            pc    <= cpu_pkg::reset_pc;
            req_q <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::st_fetch, cpu_pkg::st_mem: begin
                    req_q <= !mem_bus.done;         // drop req right after done
                    if (mem_bus.done && (state == cpu_pkg::st_fetch)) begin
                        state <= cpu_pkg::st_exec;
                    end else if (mem_bus.done) begin
                        state <= cpu_pkg::st_wb;
                    end
                end
                cpu_pkg::st_exec: begin
                    pc <= taken ? pc + 32'd4 + {imm[29:0], 2'b00} : pc + 32'd4;
                    if (is_mem) begin
                        state <= cpu_pkg::st_mem;
                    end else begin
                        state <= cpu_pkg::st_wb;
                    end
                end
                default: state <= cpu_pkg::st_fetch;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if ((state == cpu_pkg::st_fetch) && mem_bus.done) begin
            ir       <= mem_bus.rdata;
            instr_pc <= pc;
        end
        if (state == cpu_pkg::st_exec) begin
            result <= alu_y;                        // also the lw/sw address
        end
        if ((state == cpu_pkg::st_mem) && mem_bus.done && (cls == cpu_pkg::cls_load)) begin
            result <= mem_bus.rdata;
        end
    end

    // trace of the write-back stage
    assign debug_wb_pc       = instr_pc;
    assign debug_wb_rf_wdata = result;
    assign debug_wb_rf_wnum  = wnum;
    assign debug_wb_rf_wen   = (rf_we && (wnum != 5'd0)) ? 4'b1111 : 4'b0000;

endmodule

`default_nettype wire

//--- source/axi_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_master (
    input  wire                          aclk,
    input  wire                          arst_n,
    mem_bus_if.master                    mem_bus,
    output logic [cpu_pkg::word_w-1:0]   araddr,
    output logic                         arvalid,
    input  wire                          arready,
    input  wire  [cpu_pkg::word_w-1:0]   rdata,
    input  wire                          rvalid,
    output logic                         rready,
    output logic [cpu_pkg::word_w-1:0]   awaddr,
    output logic                         awvalid,
    input  wire                          awready,
    output logic [cpu_pkg::word_w-1:0]   wdata,
    output logic [3:0]                   wstrb,
    output logic                         wvalid,
    input  wire                          wready,
    input  wire                          bvalid,
    output logic                         bready
);

    typedef enum logic [1:0] {ax_idle, ax_addr, ax_resp, ax_done} ax_state_t;

    ax_state_t                   state;
    logic                        wr_q;          // current transfer is a write
    logic [cpu_pkg::word_w-1:0]  addr_q;
    logic [cpu_pkg::word_w-1:0]  rdata_q;

    assign araddr        = addr_q;
    assign awaddr        = addr_q;
    assign mem_bus.done  = (state == ax_done);
    assign mem_bus.rdata = rdata_q;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ax_idle;
            wr_q    <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else begin
            case (state)
                ax_idle: if (mem_bus.req) begin
                    wr_q    <= mem_bus.wr;
                    arvalid <= !mem_bus.wr;
                    awvalid <= mem_bus.wr;           // aw and w go out together
                    wvalid  <= mem_bus.wr;
                    state   <= ax_addr;
                end
                ax_addr: if (wr_q) begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if ((awready || !awvalid) && (wready || !wvalid)) begin
                        bready <= 1'b1;
                        state  <= ax_resp;
                    end
                end else if (arready) begin
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                    state   <= ax_resp;
                end
                ax_resp: if (wr_q ? bvalid : rvalid) begin
                    rready <= 1'b0;
                    bready <= 1'b0;
                    state  <= ax_done;               // resp ignored
                end
                default: state <= ax_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if ((state == ax_idle) && mem_bus.req) begin
            addr_q <= mem_bus.addr;
            wdata  <= mem_bus.wdata;
            wstrb  <= mem_bus.wstrb;
        end
        if ((state == ax_resp) && rready && rvalid) begin
            rdata_q <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/mycpu.sv
`timescale 1ns/1ps
`default_nettype none

module mycpu (
    input  wire                          aclk,
    input  wire                          arst_n,
    output logic [cpu_pkg::word_w-1:0]   araddr,
    output logic                         arvalid,
    input  wire                          arready,
    input  wire  [cpu_pkg::word_w-1:0]   rdata,
    input  wire                          rvalid,
    output logic                         rready,
    output logic [cpu_pkg::word_w-1:0]   awaddr,
    output logic                         awvalid,
    input  wire                          awready,
    output logic [cpu_pkg::word_w-1:0]   wdata,
    output logic [3:0]                   wstrb,
    output logic                         wvalid,
    input  wire                          wready,
    input  wire                          bvalid,
    output logic                         bready,
    output logic [cpu_pkg::word_w-1:0]   debug_wb_pc,
    output logic [cpu_pkg::word_w-1:0]   debug_wb_rf_wdata,
    output logic [3:0]                   debug_wb_rf_wen,
    output logic [4:0]                   debug_wb_rf_wnum
);

    mem_bus_if mem_bus ();   // core to axi master

    cpu_core u_core (.aclk(aclk), .arst_n(arst_n), .mem_bus(mem_bus.core),
                     .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wdata(debug_wb_rf_wdata),
                     .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum));

    axi_master u_axi_master (
        .aclk(aclk), .arst_n(arst_n), .mem_bus(mem_bus.master),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready)
    );

endmodule

`default_nettype wire

//--- dv/mycpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mycpu_assert (
    input wire                         aclk,
    input wire                         arst_n,
    input wire [cpu_pkg::word_w-1:0]   araddr,
    input wire                         arvalid,
    input wire                         arready,
    input wire [cpu_pkg::word_w-1:0]   awaddr,
    input wire                         awvalid,
    input wire                         awready,
    input wire [cpu_pkg::word_w-1:0]   wdata,
    input wire                         wvalid,
    input wire                         wready,
    input wire [3:0]                   debug_wb_rf_wen,
    input wire [4:0]                   debug_wb_rf_wnum
);

    ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("araddr or arvalid changed before arready");

    aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awaddr or awvalid changed before awready");

    w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wdata or wvalid changed before wready");

    wb_not_r0: assert property (@(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen != 4'd0 |-> debug_wb_rf_wnum != 5'd0)
        else $error("write-back trace reported for register zero");

    quiet_in_reset: assert property (@(posedge aclk)
        !arst_n |-> !arvalid && !awvalid && !wvalid)
        else $error("axi valid high during reset");

endmodule

bind mycpu mycpu_assert u_mycpu_assert (
    .aclk(aclk), .arst_n(arst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata), .wvalid(wvalid),
    .wready(wready), .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum)
);

`default_nettype wire

//--- dv/tb_mycpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mycpu;

    localparam int n_instr        = 200;
    localparam int reset_cycles   = 4;
    localparam int timeout_cycles = n_instr * 40 + reset_cycles;
    localparam logic [31:0] loop_pc = 32'(n_instr * 4);   // final beq self-loop

    logic        aclk = 1'b0;
    logic        arst_n;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] seed = 32'd60368;
    logic [31:0] mem [2048];       // axi memory with code at 0 and data from 0x1000
    logic [31:0] emem [2048];      // reference model copy
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    bit          first_read = 1'b1;

    mycpu dut (.*);

    always #20 aclk = ~aclk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return {16'h0000, r[31:16]} % n;   // upper half of the lcg state
    endfunction

    function automatic logic [31:0] fill_word(logic [10:0] idx);
        return {21'd0, idx} * 32'h9e37_79b1 + 32'h2468_ace1;
    endfunction

    task automatic fail_now(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            fail_now($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic step();
        @(posedge aclk);
        #2;
    endtask

    task automatic idle_cycles(int unsigned n);
        repeat (n) step();
    endtask

    task automatic check_quiet(string when);
        check({when, " arvalid"}, 32'd0, 32'(arvalid));
        check({when, " awvalid"}, 32'd0, 32'(awvalid));
        check({when, " wvalid"}, 32'd0, 32'(wvalid));
        check({when, " rready"}, 32'd0, 32'(rready));
        check({when, " bready"}, 32'd0, 32'(bready));
        check({when, " debug_wb_rf_wen"}, 32'd0, 32'(debug_wb_rf_wen));
    endtask

    task automatic build_program();
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
        logic [15:0]     imm;
        int              off;
        cpu_pkg::funct_t fn;
        for (int i = 0; i < 2048; i++) begin
            mem[i[10:0]] = fill_word(i[10:0]);
        end
        for (int i = 0; i < n_instr; i++) begin
            rs  = 5'(rand_below(8));
            rt  = 5'(rand_below(8));
            rd  = 5'(rand_below(8));
            imm = 16'(lcg_next() >> 16);
            case (rand_below(10))
                0, 1, 2: begin
                    case (rand_below(6))
                        0:       fn = cpu_pkg::fn_addu;
                        1:       fn = cpu_pkg::fn_subu;
                        2:       fn = cpu_pkg::fn_and;
                        3:       fn = cpu_pkg::fn_or;
                        4:       fn = cpu_pkg::fn_xor;
                        default: fn = cpu_pkg::fn_slt;
                    endcase
                    mem[i[10:0]] = {cpu_pkg::op_special, rs, rt, rd, 5'd0, fn};
                end
                3: mem[i[10:0]] = {cpu_pkg::op_addiu, rs, rt, imm};
                4: mem[i[10:0]] = {cpu_pkg::op_lui, 5'd0, rt, imm};
                5, 6: begin
                    imm = 16'h1000 + 16'(rand_below(32) * 4);   // small window so lw hits sw
                    mem[i[10:0]] = {cpu_pkg::op_lw, 5'd0, rt, imm};
                end
                7: begin
                    imm = 16'h1000 + 16'(rand_below(32) * 4);
                    mem[i[10:0]] = {cpu_pkg::op_sw, 5'd0, rt, imm};
                end
                default: begin
                    off = 1 + int'(rand_below(3));
                    if (i + 1 + off > n_instr) begin
                        off = n_instr - i - 1;               // never past the self-loop
                    end
                    if (rand_below(2) == 0) begin
                        rt = rs;                             // same register so always taken
                    end
                    mem[i[10:0]] = {cpu_pkg::op_beq, rs, rt, 16'(off)};
                end
            endcase
        end
        mem[loop_pc[12:2]] = {cpu_pkg::op_beq, 5'd0, 5'd0, 16'hffff};   // beq r0,r0,-1
    endtask

    // ISA model that builds the expected write-back trace
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ins;
        logic [31:0] se;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        wb;
        regs = '{default: 32'd0};
        emem = mem;
        pc   = cpu_pkg::reset_pc;
        while (pc != loop_pc) begin
            ins  = mem[pc[12:2]];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            se   = {{16{ins[15]}}, ins[15:0]};
            npc  = pc + 32'd4;
            dest = ins[20:16];
            wb   = 1'b1;
            v    = 32'd0;
            case (ins[31:26])
                cpu_pkg::op_special: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        cpu_pkg::fn_addu: v = a + b;
                        cpu_pkg::fn_subu: v = a - b;
                        cpu_pkg::fn_and:  v = a & b;
                        cpu_pkg::fn_or:   v = a | b;
                        cpu_pkg::fn_xor:  v = a ^ b;
                        cpu_pkg::fn_slt:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wb = 1'b0;
                    endcase
                end
                cpu_pkg::op_addiu: v = a + se;
                cpu_pkg::op_lui:   v = {ins[15:0], 16'h0000};
                cpu_pkg::op_lw: begin
                    addr = a + se;
                    v    = emem[addr[12:2]];
                end
                cpu_pkg::op_sw: begin
                    addr = a + se;
                    emem[addr[12:2]] = b;
                    wb = 1'b0;
                end
                cpu_pkg::op_beq: begin
                    wb = 1'b0;
                    if (a == b) begin
                        npc = pc + 32'd4 + {se[29:0], 2'b00};   // no delay slot
                    end
                end
                default: wb = 1'b0;
            endcase
            if (wb && (dest != 5'd0)) begin
                regs[dest] = v;
                exp_pc.push_back(pc);
                exp_num.push_back(dest);
                exp_data.push_back(v);
            end
            pc = npc;
        end
    endtask

    task automatic serve_read();
        logic [31:0] a;
        a = araddr;
        if (first_read) begin
            check("first fetch address", cpu_pkg::reset_pc, a);
            first_read = 1'b0;
        end
        if (a >= 32'h2000) begin
            fail_now($sformatf("read from address %h outside the memory model", a));
        end
        idle_cycles(rand_below(8));
        arready = 1'b1;
        step();
        arready = 1'b0;
        idle_cycles(rand_below(8));
        check("rready before rvalid", 32'd1, 32'(rready));
        rdata  = mem[a[12:2]];
        rvalid = 1'b1;
        step();
        rvalid = 1'b0;
    endtask

    task automatic serve_write();
        logic [31:0] a;
        logic [31:0] d;
        a = awaddr;
        d = wdata;
        check("sw wstrb", 32'hf, 32'(wstrb));
        if ((a < 32'h1000) || (a >= 32'h2000) || !wvalid) begin
            fail_now($sformatf("bad write request to address %h", a));
        end
        idle_cycles(rand_below(8));
        awready = 1'b1;
        step();
        awready = 1'b0;
        idle_cycles(rand_below(8));
        wready = 1'b1;
        step();
        wready = 1'b0;
        idle_cycles(rand_below(8));
        check("bready before bvalid", 32'd1, 32'(bready));
        bvalid = 1'b1;
        step();
        bvalid = 1'b0;
        mem[a[12:2]] = d;
    endtask

    task automatic serve_memory();
        forever begin
            step();
            if (arvalid) begin
                serve_read();
            end else if (awvalid) begin
                serve_write();
            end
        end
    endtask

    task automatic watch_trace();
        int idx;
        int cycles;
        idx    = 0;
        cycles = reset_cycles;
        while (!((idx == exp_pc.size()) && arvalid && (araddr == loop_pc))) begin
            step();
            cycles++;
            if (cycles > timeout_cycles) begin
                fail_now($sformatf("timeout after %0d cycles with %0d of %0d write-backs seen",
                                   cycles, idx, exp_pc.size()));
            end
            if (debug_wb_rf_wen != 4'b0000) begin
                if (idx >= exp_pc.size()) begin
                    fail_now("write-back seen after the last expected one");
                end
                check($sformatf("trace %0d pc", idx), exp_pc[idx], debug_wb_pc);
                check($sformatf("trace %0d wnum", idx), 32'(exp_num[idx]),
                      32'(debug_wb_rf_wnum));
                check($sformatf("trace %0d wdata", idx), exp_data[idx], debug_wb_rf_wdata);
                check($sformatf("trace %0d wen", idx), 32'hf, 32'(debug_wb_rf_wen));
                idx++;
            end
        end
    endtask

    initial begin
        arst_n  = 1'b0;
        arready = 1'b0;
        rdata   = 32'd0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        build_program();
        run_model();
        repeat (reset_cycles) begin
            step();
            check_quiet("in reset");
        end
        arst_n = 1'b1;
        step();
        check_quiet("first cycle after reset");
        fork
            serve_memory();
            watch_trace();
        join_any
        for (int i = 1024; i < 2048; i++) begin
            check($sformatf("data word %h", 4 * i), emem[i[10:0]], mem[i[10:0]]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
source/cpu_pkg.sv
source/mem_bus_if.sv
source/reg_file.sv
source/alu.sv
source/decoder.sv
source/cpu_core.sv
source/axi_master.sv
source/mycpu.sv
dv/mycpu_assert.sv
dv/tb_mycpu.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, decide on the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_mycpu -o sim_tb_mycpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_mycpu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
